/* Bender.yml */
package:
  name: tracker

sources:
  - files:
      - verilog/video_pkg.sv
      - verilog/pixel_pkg.sv
      - verilog/video_timing.sv
      - verilog/pixel_mask.sv
      - verilog/divider.sv
      - verilog/center_of_mass.sv
      - verilog/video_mux.sv
      - verilog/tracker_top.sv
  - target: test
    files:
      - test/tracker_chk.sv
      - test/tracker_tb.sv

/* files.f */
verilog/video_pkg.sv
verilog/pixel_pkg.sv
verilog/video_timing.sv
verilog/pixel_mask.sv
verilog/divider.sv
verilog/center_of_mass.sv
verilog/video_mux.sv
verilog/tracker_top.sv
test/tracker_chk.sv
test/tracker_tb.sv

/* test/tracker_chk.sv */
`timescale 1ns/100ps

module tracker_chk (
    input logic clk_pixel,
    input logic recent_reset,
    input logic start_i,
    input logic busy_i,
    input logic new_frame_i,
    input logic active_i,
    input logic hsync_i
);
    int error_count = 0;

    // Vertical blanking has to outlast the division
    start_idle: assert property (@(posedge clk_pixel) disable iff (recent_reset)
        start_i |-> !busy_i)
        else begin
            error_count++;
            $error("divider start arrived while a division was running");
        end

    frame_pulse: assert property (@(posedge clk_pixel) disable iff (recent_reset)
        new_frame_i |=> !new_frame_i)
        else begin
            error_count++;
            $error("new_frame_o lasted longer than one cycle");
        end

    sync_blank: assert property (@(posedge clk_pixel) disable iff (recent_reset)
        !(hsync_i && active_i))
        else begin
            error_count++;
            $error("hsync high inside the active area");
        end

endmodule

bind center_of_mass tracker_chk com_chk (
    .clk_pixel(clk_pixel), .recent_reset(recent_reset), .start_i(div_start),
    .busy_i(state == DIVIDE), .new_frame_i(1'b0), .active_i(1'b0), .hsync_i(1'b0));

bind video_timing tracker_chk timing_chk (
    .clk_pixel(clk_pixel), .recent_reset(recent_reset), .start_i(1'b0), .busy_i(1'b0),
    .new_frame_i(new_frame_o), .active_i(active_o), .hsync_i(hsync_o));

/* test/tracker_tb.sv */
`timescale 1ns/100ps

module tracker_tb;
    import video_pkg::*;
    import pixel_pkg::*;

    localparam int H_ACT = 32, H_FP = 4, H_SW = 4, H_BP = 4;
    localparam int V_ACT = 24, V_FP = 2, V_SW = 2, V_BP = 2;
    localparam int H_TOTAL = H_ACT + H_FP + H_SW + H_BP;
    localparam int V_TOTAL = V_ACT + V_FP + V_SW + V_BP;
    localparam int RESET_CYCLES = 8;
    localparam int NUM_FRAMES = 8;
    localparam int TIMEOUT_CYCLES = RESET_CYCLES + (NUM_FRAMES + 1) * H_TOTAL * V_TOTAL;

    // Frame 0 on the left
    localparam logic [0:NUM_FRAMES-1][1:0] MODE_SEQ =
        {2'd0, 2'd1, 2'd2, 2'd2, 2'd2, 2'd0, 2'd1, 2'd2};
    localparam logic [0:NUM_FRAMES-1][3:0] LO_SEQ =
        {4'd4, 4'd2, 4'd6, 4'd0, 4'd9, 4'd1, 4'd5, 4'd3};
    localparam logic [0:NUM_FRAMES-1][3:0] HI_SEQ =
        {4'd11, 4'd9, 4'd13, 4'd3, 4'd15, 4'd10, 4'd12, 4'd12};
    localparam logic [0:NUM_FRAMES-1] XHAIR_SEQ = 8'b0001_0111;
    localparam logic [0:NUM_FRAMES-1] DARK_SEQ  = 8'b0000_1000; // All-black frame

    bit clk_pixel;
    logic recent_reset;
    rgb565_t pixel_i;
    thresh_t thresh_lo_i, thresh_hi_i;
    display_mode_t mode_i;
    logic crosshair_en_i;
    hcount_t hcount_o, com_x_o;
    vcount_t vcount_o, com_y_o;
    logic active_o, de_o, hsync_o, vsync_o, com_valid_o;
    rgb888_t rgb_o;

    int seed = 86266;
    int cycle_count, reset_count, frame_no, de_count, com_expected, com_checked;
    int tx, ty; // Coordinate the DUT should be presenting
    logic [31:0] frame_val;
    logic dark, running, finished, com_pending;
    coord_sum_t sum_x, sum_y, pix_count;
    hcount_t ref_com_x;
    vcount_t ref_com_y;
    rgb888_t rgb_q[$];
    logic [2:0] sync_q[$]; // de, hsync, vsync

    always #20 clk_pixel = ~clk_pixel;

    tracker_top #(
        .H_ACTIVE(H_ACT), .H_FRONT(H_FP), .H_SYNC(H_SW), .H_BACK(H_BP),
        .V_ACTIVE(V_ACT), .V_FRONT(V_FP), .V_SYNC(V_SW), .V_BACK(V_BP)
    ) DUT (
        .clk_pixel(clk_pixel), .recent_reset(recent_reset), .pixel_i(pixel_i),
        .thresh_lo_i(thresh_lo_i), .thresh_hi_i(thresh_hi_i), .mode_i(mode_i),
        .crosshair_en_i(crosshair_en_i), .hcount_o(hcount_o), .vcount_o(vcount_o),
        .active_o(active_o), .rgb_o(rgb_o), .de_o(de_o), .hsync_o(hsync_o),
        .vsync_o(vsync_o), .com_x_o(com_x_o), .com_y_o(com_y_o), .com_valid_o(com_valid_o));

    task automatic abort_run();
        $display("*** FAILED ***");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic report_problem(string msg);
        $display("ERROR at %0d ns: %s", $time, msg);
        abort_run();
    endtask

    task automatic rgb_compare(string name, rgb888_t got, rgb888_t exp);
        if (got !== exp) begin
            $display("CHECK FAILED at %0d ns: %s = %h, expected %h", $time, name, got, exp);
            abort_run();
        end
    endtask

    task automatic hcount_compare(string name, hcount_t got, hcount_t exp);
        if (got !== exp) begin
            $display("CHECK FAILED at %0d ns: %s = %0d, expected %0d", $time, name, got, exp);
            abort_run();
        end
    endtask

    task automatic vcount_compare(string name, vcount_t got, vcount_t exp);
        if (got !== exp) begin
            $display("CHECK FAILED at %0d ns: %s = %0d, expected %0d", $time, name, got, exp);
            abort_run();
        end
    endtask

    task automatic bit_compare(string name, logic got, logic exp);
        if (got !== exp) begin
            $display("CHECK FAILED at %0d ns: %s = %b, expected %b", $time, name, got, exp);
            abort_run();
        end
    endtask

    // Stimulus pattern, varied per frame by v
    function automatic rgb565_t pixel_for(int x, int y, logic [31:0] v);
        return {5'(x) ^ v[4:0], 5'(y) ^ v[9:5], x[0], 5'(x + y) + v[14:10]};
    endfunction

    function automatic rgb888_t expand_565(rgb565_t p);
        return {p[15:11], 3'b000, p[10:5], 2'b00, p[4:0], 3'b000};
    endfunction

    function automatic channel_t luma_of(rgb888_t c);
        int sum;
        sum = 77 * c[23:16] + 150 * c[15:8] + 29 * c[7:0];
        return channel_t'(sum >> 8);
    endfunction

    function automatic logic in_window(channel_t luma, thresh_t lo, thresh_t hi);
        return (int'(luma) > 16 * lo) && (int'(luma) <= 16 * hi + 15);
    endfunction

    function automatic coord_sum_t mean_of(coord_sum_t sum, coord_sum_t count);
        return sum / count; // Rounds down
    endfunction

    function automatic rgb888_t expected_pixel(hcount_t x, vcount_t y, rgb565_t p, logic act);
        rgb888_t c;
        channel_t l;
        c = expand_565(p);
        l = luma_of(c);
        if (!act)
            return '0;
        if (crosshair_en_i && (x == ref_com_x || y == ref_com_y))
            return 24'h00FF00;
        case (mode_i)
            MODE_LUMA: return {l, l, l};
            MODE_MASK: return in_window(l, thresh_lo_i, thresh_hi_i) ? 24'hFFFFFF : 24'h000000;
            default:   return c;
        endcase
    endfunction

    task automatic start_frame();
        if (frame_no > 0 && de_count != H_ACT * V_ACT)
            report_problem($sformatf("frame %0d showed %0d de_o cycles instead of %0d",
                                     frame_no - 1, de_count, H_ACT * V_ACT));
        if (com_pending)
            report_problem("no com_valid_o pulse after a frame with in-window pixels");
        hcount_compare("com_x_o", com_x_o, ref_com_x); // Held result
        vcount_compare("com_y_o", com_y_o, ref_com_y);
        de_count = 0;
        if (frame_no == NUM_FRAMES) begin
            finished = 1'b1;
        end else begin
            mode_i         = display_mode_t'(MODE_SEQ[frame_no]);
            thresh_lo_i    = LO_SEQ[frame_no];
            thresh_hi_i    = HI_SEQ[frame_no];
            crosshair_en_i = XHAIR_SEQ[frame_no];
            dark           = DARK_SEQ[frame_no];
            frame_val      = $random(seed);
            sum_x          = '0;
            sum_y          = '0;
            pix_count      = '0;
            frame_no++;
        end
    endtask

    task automatic pixel_cycle();
        logic act;
        logic [2:0] sync;
        rgb565_t pix;
        act = (tx < H_ACT) && (ty < V_ACT);
        hcount_compare("hcount_o", hcount_o, hcount_t'(tx));
        vcount_compare("vcount_o", vcount_o, vcount_t'(ty));
        bit_compare("active_o", active_o, act);
        if (DUT.com.com_chk.error_count + DUT.timing.timing_chk.error_count != 0)
            report_problem("a bound assertion failed");
        if (rgb_q.size() == PIPE_DELAY) begin
            sync = sync_q.pop_front();
            rgb_compare("rgb_o", rgb_o, rgb_q.pop_front());
            bit_compare("de_o", de_o, sync[2]);
            bit_compare("hsync_o", hsync_o, sync[1]);
            bit_compare("vsync_o", vsync_o, sync[0]);
        end
        if (de_o)
            de_count++;
        if (com_valid_o) begin
            if (!com_pending)
                report_problem("com_valid_o pulsed with no result due");
            hcount_compare("com_x_o", com_x_o, ref_com_x);
            vcount_compare("com_y_o", com_y_o, ref_com_y);
            com_pending = 1'b0;
            com_checked++;
        end
        if (tx == 0 && ty == 0)
            start_frame();
        if (!finished) begin
            // Sums are complete on the first blanking line
            if (tx == 0 && ty == V_ACT && pix_count != 0) begin
                ref_com_x   = hcount_t'(mean_of(sum_x, pix_count));
                ref_com_y   = vcount_t'(mean_of(sum_y, pix_count));
                com_pending = 1'b1;
                com_expected++;
            end
            pix = dark ? '0 : pixel_for(tx, ty, frame_val);
            pixel_i = pix;
            if (act && in_window(luma_of(expand_565(pix)), thresh_lo_i, thresh_hi_i)) begin
                sum_x += coord_sum_t'(tx);
                sum_y += coord_sum_t'(ty);
                pix_count++;
            end
            rgb_q.push_back(expected_pixel(hcount_t'(tx), vcount_t'(ty), pix, act));
            sync_q.push_back({act, tx >= H_ACT + H_FP && tx < H_ACT + H_FP + H_SW,
                              ty >= V_ACT + V_FP && ty < V_ACT + V_FP + V_SW});
            tx = (tx == H_TOTAL - 1) ? 0 : tx + 1;
            if (tx == 0)
                ty = (ty == V_TOTAL - 1) ? 0 : ty + 1;
        end
    endtask

    always @(negedge clk_pixel) begin
        cycle_count++;
        if (cycle_count > TIMEOUT_CYCLES)
            report_problem($sformatf("timeout after %0d cycles, frames did not complete",
                                     cycle_count));
        if (recent_reset) begin
            reset_count++;
            if (reset_count == RESET_CYCLES) begin
                recent_reset = 1'b0;
                running      = 1'b1;
            end
        end
        if (running && !finished)
            pixel_cycle();
    end

    initial begin
        recent_reset   = 1'b1;
        pixel_i        = '0;
        thresh_lo_i    = '0;
        thresh_hi_i    = '0;
        mode_i         = MODE_CAMERA;
        crosshair_en_i = 1'b0;
        running        = 1'b0;
        finished       = 1'b0;
        com_pending    = 1'b0;
        dark           = 1'b0;
        ref_com_x      = '0; // Reset value of the result
        ref_com_y      = '0;
        wait (finished);
        if (com_expected == 0 || com_checked != com_expected) begin
            report_problem("centre-of-mass results were missing");
        end else begin
            $display("*** PASSED ***");
            $finish;
        end
    end

endmodule

/* verilog/center_of_mass.sv */
`timescale 1ns/100ps

module center_of_mass (
    input  logic               clk_pixel,
    input  logic               recent_reset,
    input  video_pkg::hcount_t x_i,
    input  video_pkg::vcount_t y_i,
    input  logic               valid_i,
    input  logic               tabulate_i,
    output video_pkg::hcount_t com_x_o,
    output video_pkg::vcount_t com_y_o,
    output logic               com_valid_o
);
    import video_pkg::*;

    typedef enum logic {ACCUMULATE, DIVIDE} com_state_t;

    com_state_t state;
    coord_sum_t x_sum;
    coord_sum_t y_sum;
    coord_sum_t pix_count;
    coord_sum_t quot_x;
    coord_sum_t quot_y;
    logic div_start;
    logic done_x;
    logic done_y;
    logic both_done;

    always_ff @(posedge clk_pixel) begin
        if (recent_reset || tabulate_i) begin
            x_sum     <= '0;
            y_sum     <= '0;
            pix_count <= '0;
        end else if (valid_i) begin
            x_sum     <= x_sum + coord_sum_t'(x_i);
            y_sum     <= y_sum + coord_sum_t'(y_i);
            pix_count <= pix_count + 1'b1;
        end
    end

    // Empty frames keep the previous result
    assign div_start = tabulate_i && (pix_count != '0);

    divider div_x (
        .clk_pixel(clk_pixel), .recent_reset(recent_reset), .start_i(div_start),
        .dividend_i(x_sum), .divisor_i(pix_count), .quotient_o(quot_x), .done_o(done_x));

    divider div_y (
        .clk_pixel(clk_pixel), .recent_reset(recent_reset), .start_i(div_start),
        .dividend_i(y_sum), .divisor_i(pix_count), .quotient_o(quot_y), .done_o(done_y));

    assign both_done = done_x && done_y; // Both dividers run the same number of steps

    always_ff @(posedge clk_pixel) begin
        if (recent_reset) begin
            state       <= ACCUMULATE;
            com_x_o     <= '0;
            com_y_o     <= '0;
            com_valid_o <= 1'b0;
        end else begin
            com_valid_o <= 1'b0;
            case (state)
                ACCUMULATE: begin
                    if (div_start) state <= DIVIDE;
                end
                default: begin
                    if (both_done) begin
                        com_x_o     <= hcount_t'(quot_x);
                        com_y_o     <= vcount_t'(quot_y);
                        com_valid_o <= 1'b1;
                        state       <= ACCUMULATE;
                    end
                end
            endcase
        end
    end

endmodule

/* verilog/divider.sv */
`timescale 1ns/100ps

module divider (
    input  logic                  clk_pixel,
    input  logic                  recent_reset,
    input  logic                  start_i,
    input  video_pkg::coord_sum_t dividend_i,
    input  video_pkg::coord_sum_t divisor_i,
    output video_pkg::coord_sum_t quotient_o,
    output logic                  done_o
);
    import video_pkg::*;

    localparam int BITS  = $bits(coord_sum_t);
    localparam int CNT_W = $clog2(BITS);

    typedef enum logic [1:0] {IDLE, RUN, DONE} div_state_t;

    div_state_t state;
    coord_sum_t divisor_q;
    coord_sum_t remainder_q;
    coord_sum_t quotient_q; // Holds the dividend, shifted out as quotient bits come in
    logic [CNT_W-1:0] bit_cnt;
    logic [BITS:0] trial;   // Top bit set means the subtraction went negative

    assign trial      = {remainder_q, quotient_q[BITS-1]} - {1'b0, divisor_q};
    assign quotient_o = quotient_q;
    assign done_o     = (state == DONE);

    always_ff @(posedge clk_pixel) begin
        if (recent_reset) begin
            state <= IDLE;
        end else begin
            case (state)
                IDLE: if (start_i) state <= RUN;
                RUN:  if (bit_cnt == '0) state <= DONE;
                default: state <= IDLE; // DONE lasts one cycle
            endcase
        end
    end

    always_ff @(posedge clk_pixel) begin
        if (state == IDLE && start_i) begin
            divisor_q   <= divisor_i;
            quotient_q  <= dividend_i;
            remainder_q <= '0;
            bit_cnt     <= CNT_W'(BITS - 1);
        end else if (state == RUN) begin
            bit_cnt <= bit_cnt - 1'b1;
            if (!trial[BITS]) begin
                remainder_q <= trial[BITS-1:0];
                quotient_q  <= {quotient_q[BITS-2:0], 1'b1};
            end else begin
                remainder_q <= {remainder_q[BITS-2:0], quotient_q[BITS-1]}; // Restore
                quotient_q  <= {quotient_q[BITS-2:0], 1'b0};
            end
        end
    end

endmodule

/* verilog/pixel_mask.sv */
`timescale 1ns/100ps

module pixel_mask (
    input  logic                clk_pixel,
    input  logic                recent_reset,
    input  pixel_pkg::rgb565_t  pixel_i,
    input  pixel_pkg::thresh_t  thresh_lo_i,
    input  pixel_pkg::thresh_t  thresh_hi_i,
    output pixel_pkg::rgb888_t  colour_o,
    output pixel_pkg::channel_t luma_o,
    output logic                mask_o
);
    import pixel_pkg::*;

    channel_t red_exp;
    channel_t green_exp;
    channel_t blue_exp;
    logic [15:0] luma_sum; // Max is 256 * 255

    rgb888_t  colour_s1;
    channel_t luma_s1;
    channel_t lower_bound;
    channel_t upper_bound;

    // Zero-filled expansion to 8 bits per channel
    assign red_exp   = {pixel_i[15:11], 3'b000};
    assign green_exp = {pixel_i[10:5], 2'b00};
    assign blue_exp  = {pixel_i[4:0], 3'b000};

    assign luma_sum = LUMA_R * red_exp + LUMA_G * green_exp + LUMA_B * blue_exp;

    // Stage 1
    always_ff @(posedge clk_pixel) begin
        colour_s1 <= {red_exp, green_exp, blue_exp};
        luma_s1   <= luma_sum[15:8];
    end

    assign lower_bound = {thresh_lo_i, 4'b0000};
    assign upper_bound = {thresh_hi_i, 4'b1111};

    // Stage 2, mask plus colour and luma kept in step with it
    always_ff @(posedge clk_pixel) begin
        if (recent_reset) begin
            mask_o <= 1'b0;
        end else begin
            mask_o <= (luma_s1 > lower_bound) && (luma_s1 <= upper_bound);
        end
    end

    always_ff @(posedge clk_pixel) begin
        colour_o <= colour_s1;
        luma_o   <= luma_s1;
    end

endmodule

/* verilog/pixel_pkg.sv */
package pixel_pkg;

    typedef logic [15:0] rgb565_t;  // Input pixel, 5:6:5
    typedef logic [23:0] rgb888_t;  // Red in the top byte
    typedef logic [7:0]  channel_t; // One channel or the luma
    typedef logic [3:0]  thresh_t;  // Threshold nibble

    // Luma weights, sum is 256 so the shifted result stays in 8 bits
    localparam channel_t LUMA_R = 8'd77;
    localparam channel_t LUMA_G = 8'd150;
    localparam channel_t LUMA_B = 8'd29;

    localparam rgb888_t CROSSHAIR_COLOUR = 24'h00FF00;

    // Code 3 is not listed and shows the camera image
    typedef enum logic [1:0] {
        MODE_CAMERA = 2'd0,
        MODE_LUMA   = 2'd1,
        MODE_MASK   = 2'd2
    } display_mode_t;

endpackage

/* verilog/tracker_top.sv */
`timescale 1ns/100ps

module tracker_top #(
    parameter int H_ACTIVE = video_pkg::H_ACTIVE,
    parameter int H_FRONT  = video_pkg::H_FRONT,
    parameter int H_SYNC   = video_pkg::H_SYNC,
    parameter int H_BACK   = video_pkg::H_BACK,
    parameter int V_ACTIVE = video_pkg::V_ACTIVE,
    parameter int V_FRONT  = video_pkg::V_FRONT,
    parameter int V_SYNC   = video_pkg::V_SYNC,
    parameter int V_BACK   = video_pkg::V_BACK
) (
    input  logic                     clk_pixel,
    input  logic                     recent_reset,
    input  pixel_pkg::rgb565_t       pixel_i,
    input  pixel_pkg::thresh_t       thresh_lo_i,
    input  pixel_pkg::thresh_t       thresh_hi_i,
    input  pixel_pkg::display_mode_t mode_i,
    input  logic                     crosshair_en_i,
    output video_pkg::hcount_t       hcount_o,
    output video_pkg::vcount_t       vcount_o,
    output logic                     active_o,
    output pixel_pkg::rgb888_t       rgb_o,
    output logic                     de_o,
    output logic                     hsync_o,
    output logic                     vsync_o,
    output video_pkg::hcount_t       com_x_o,
    output video_pkg::vcount_t       com_y_o,
    output logic                     com_valid_o
);
    import video_pkg::*;
    import pixel_pkg::*;

    localparam int STAGES = PIPE_DELAY - 1; // Stages before the output register

    logic hsync;
    logic vsync;
    logic new_frame;
    rgb888_t  colour;
    channel_t luma;
    logic mask;

    hcount_t x_pipe [STAGES];
    vcount_t y_pipe [STAGES];
    logic [STAGES-1:0] active_pipe;
    logic [STAGES-1:0] hsync_pipe;
    logic [STAGES-1:0] vsync_pipe;

    video_timing #(
        .H_ACTIVE(H_ACTIVE), .H_FRONT(H_FRONT), .H_SYNC(H_SYNC), .H_BACK(H_BACK),
        .V_ACTIVE(V_ACTIVE), .V_FRONT(V_FRONT), .V_SYNC(V_SYNC), .V_BACK(V_BACK)
    ) timing (
        .clk_pixel(clk_pixel), .recent_reset(recent_reset),
        .hcount_o(hcount_o), .vcount_o(vcount_o), .active_o(active_o),
        .hsync_o(hsync), .vsync_o(vsync), .new_frame_o(new_frame));

    pixel_mask mask_stage (
        .clk_pixel(clk_pixel), .recent_reset(recent_reset), .pixel_i(pixel_i),
        .thresh_lo_i(thresh_lo_i), .thresh_hi_i(thresh_hi_i),
        .colour_o(colour), .luma_o(luma), .mask_o(mask));

    // Coordinates follow the pixel through both mask stages
    always_ff @(posedge clk_pixel) begin
        x_pipe[0] <= hcount_o;
        y_pipe[0] <= vcount_o;
        for (int i = 1; i < STAGES; i++) begin
            x_pipe[i] <= x_pipe[i-1];
            y_pipe[i] <= y_pipe[i-1];
        end
    end

    always_ff @(posedge clk_pixel) begin
        if (recent_reset) begin
            active_pipe <= '0;
            hsync_pipe  <= '0;
            vsync_pipe  <= '0;
        end else begin
            active_pipe <= {active_pipe[STAGES-2:0], active_o};
            hsync_pipe  <= {hsync_pipe[STAGES-2:0], hsync};
            vsync_pipe  <= {vsync_pipe[STAGES-2:0], vsync};
        end
    end

    center_of_mass com (
        .clk_pixel(clk_pixel), .recent_reset(recent_reset),
        .x_i(x_pipe[STAGES-1]), .y_i(y_pipe[STAGES-1]),
        .valid_i(mask && active_pipe[STAGES-1]), .tabulate_i(new_frame),
        .com_x_o(com_x_o), .com_y_o(com_y_o), .com_valid_o(com_valid_o));

    video_mux mux (
        .clk_pixel(clk_pixel), .recent_reset(recent_reset),
        .mode_i(mode_i), .crosshair_en_i(crosshair_en_i),
        .active_i(active_pipe[STAGES-1]), .hsync_i(hsync_pipe[STAGES-1]),
        .vsync_i(vsync_pipe[STAGES-1]), .mask_i(mask),
        .colour_i(colour), .luma_i(luma),
        .x_i(x_pipe[STAGES-1]), .y_i(y_pipe[STAGES-1]),
        .com_x_i(com_x_o), .com_y_i(com_y_o),
        .rgb_o(rgb_o), .de_o(de_o), .hsync_o(hsync_o), .vsync_o(vsync_o));

endmodule

/* verilog/video_mux.sv */
`timescale 1ns/100ps

module video_mux (
    input  logic                     clk_pixel,
    input  logic                     recent_reset,
    input  pixel_pkg::display_mode_t mode_i,
    input  logic                     crosshair_en_i,
    input  logic                     active_i,
    input  logic                     hsync_i,
    input  logic                     vsync_i,
    input  logic                     mask_i,
    input  pixel_pkg::rgb888_t       colour_i,
    input  pixel_pkg::channel_t      luma_i,
    input  video_pkg::hcount_t       x_i,
    input  video_pkg::vcount_t       y_i,
    input  video_pkg::hcount_t       com_x_i,
    input  video_pkg::vcount_t       com_y_i,
    output pixel_pkg::rgb888_t       rgb_o,
    output logic                     de_o,
    output logic                     hsync_o,
    output logic                     vsync_o
);
    import pixel_pkg::*;

    rgb888_t base_pixel;
    rgb888_t out_pixel;

    always_comb begin
        case (mode_i)
            MODE_LUMA: base_pixel = {luma_i, luma_i, luma_i}; // Grey
            MODE_MASK: base_pixel = mask_i ? 24'hFFFFFF : 24'h000000;
            default:   base_pixel = colour_i;
        endcase
        out_pixel = base_pixel;
        if (crosshair_en_i && ((x_i == com_x_i) || (y_i == com_y_i)))
            out_pixel = CROSSHAIR_COLOUR;
    end

    always_ff @(posedge clk_pixel) begin
        rgb_o <= active_i ? out_pixel : '0; // Black in blanking
    end

    always_ff @(posedge clk_pixel) begin
        if (recent_reset) begin
            de_o    <= 1'b0;
            hsync_o <= 1'b0;
            vsync_o <= 1'b0;
        end else begin
            de_o    <= active_i;
            hsync_o <= hsync_i;
            vsync_o <= vsync_i;
        end
    end

endmodule

/* verilog/video_pkg.sv */
package video_pkg;

    // Default frame geometry, 1280x720 at 60 Hz
    localparam int H_ACTIVE = 1280;
    localparam int H_FRONT  = 110;
    localparam int H_SYNC   = 40;
    localparam int H_BACK   = 220;

    localparam int V_ACTIVE = 720;
    localparam int V_FRONT  = 5;
    localparam int V_SYNC   = 5;
    localparam int V_BACK   = 20;

    typedef logic [10:0] hcount_t; // Pixel column
    typedef logic [9:0]  vcount_t; // Line number

    // Frame sum of coordinates or a pixel count
    typedef logic [31:0] coord_sum_t;

    // Cycles from a coordinate leaving the timing generator to its output pixel
    localparam int PIPE_DELAY = 3;

endpackage

/* verilog/video_timing.sv */
`timescale 1ns/100ps

module video_timing #(
    parameter int H_ACTIVE = video_pkg::H_ACTIVE,
    parameter int H_FRONT  = video_pkg::H_FRONT,
    parameter int H_SYNC   = video_pkg::H_SYNC,
    parameter int H_BACK   = video_pkg::H_BACK,
    parameter int V_ACTIVE = video_pkg::V_ACTIVE,
    parameter int V_FRONT  = video_pkg::V_FRONT,
    parameter int V_SYNC   = video_pkg::V_SYNC,
    parameter int V_BACK   = video_pkg::V_BACK
) (
    input  logic              clk_pixel,
    input  logic              recent_reset,
    output video_pkg::hcount_t hcount_o,
    output video_pkg::vcount_t vcount_o,
    output logic              active_o,
    output logic              hsync_o,
    output logic              vsync_o,
    output logic              new_frame_o
);
    import video_pkg::*;

    localparam int H_TOTAL = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;
    localparam int V_TOTAL = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;

    localparam hcount_t H_LAST       = hcount_t'(H_TOTAL - 1);
    localparam vcount_t V_LAST       = vcount_t'(V_TOTAL - 1);
    localparam hcount_t H_SYNC_START = hcount_t'(H_ACTIVE + H_FRONT);
    localparam hcount_t H_SYNC_END   = hcount_t'(H_ACTIVE + H_FRONT + H_SYNC);
    localparam vcount_t V_SYNC_START = vcount_t'(V_ACTIVE + V_FRONT);
    localparam vcount_t V_SYNC_END   = vcount_t'(V_ACTIVE + V_FRONT + V_SYNC);

    always_ff @(posedge clk_pixel) begin
        if (recent_reset) begin
            hcount_o <= '0;
            vcount_o <= '0;
        end else if (hcount_o == H_LAST) begin
            hcount_o <= '0;
            vcount_o <= (vcount_o == V_LAST) ? '0 : vcount_o + 1'b1; // Wrap at end of frame
        end else begin
            hcount_o <= hcount_o + 1'b1;
        end
    end

    assign active_o = (hcount_o < hcount_t'(H_ACTIVE)) && (vcount_o < vcount_t'(V_ACTIVE));
    assign hsync_o  = (hcount_o >= H_SYNC_START) && (hcount_o < H_SYNC_END);
    assign vsync_o  = (vcount_o >= V_SYNC_START) && (vcount_o < V_SYNC_END);

    // First pixel of the first blanking line
    assign new_frame_o = (hcount_o == '0) && (vcount_o == vcount_t'(V_ACTIVE));

endmodule
